// File: busDecoder.sv
//****************************************
// Brings the processor bus into the ck933 domain, makes a one
// clock write strobe and decodes the address regions
//****************************************
`timescale 1ns/1ps
`default_nettype none

module busDecoder (
    input  wire                                  ck933,
    input  wire                                  clockCounterEn,
    input  wire                                  nCs,
    input  wire                                  nWe,
    input  wire                                  nRd,
    input  wire legacyPkg::busAddrT              addr,
    input  wire legacyPkg::busWordT              dataIn,
    output legacyPkg::busAddrT                   regAddr,
    output legacyPkg::busWordT                   writeData,
    output logic                                 writeStrobe,
    output logic                                 readActive,
    output logic                                 miscSel,
    output logic [legacyPkg::numDacChannels-1:0] chanSel
);

    logic nCsReg;
    logic nWeReg;
    logic nRdReg;
    logic nCsDly;
    logic nWeDly;

    //****************************************
    // Bus input registers
    //****************************************
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            nCsReg      <= 1'b1;
            nWeReg      <= 1'b1;
            nRdReg      <= 1'b1;
            nCsDly      <= 1'b1;
            nWeDly      <= 1'b1;
            regAddr     <= '0;
            writeStrobe <= 1'b0;
        end else begin
            nCsReg  <= nCs;
            nWeReg  <= nWe;
            nRdReg  <= nRd;
            nCsDly  <= nCsReg;
            nWeDly  <= nWeReg;
            regAddr <= addr;
            // Rising nWe ends the write while chip select is low
            writeStrobe <= nWeReg & ~nWeDly & ~nCsDly;
        end
    end

    // Write data follows the bus pins every clock
    always_ff @(posedge ck933) begin
        writeData <= dataIn;
    end

    assign readActive = ~nCsReg & ~nRdReg;

    //****************************************
    // Region decode
    //****************************************
    assign miscSel = ~nCsReg & ((regAddr & legacyPkg::regionMask) == legacyPkg::regionMisc);

    always_comb begin
        chanSel = '0;
        if (!nCsReg) begin
            case (regAddr & legacyPkg::regionMask)
                legacyPkg::regionInterp0: chanSel[0] = 1'b1;
                legacyPkg::regionInterp1: chanSel[1] = 1'b1;
                legacyPkg::regionInterp2: chanSel[2] = 1'b1;
                default:                  chanSel    = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: dacChannel.sv
//****************************************
// One DAC output channel. Picks a sample stream by its select
// code and holds the upper bits until the next sync
//****************************************
`timescale 1ns/1ps
`default_nettype none

module dacChannel (
    input  wire                      ck933,
    input  wire                      clockCounterEn,
    input  wire                      softReset,
    input  wire legacyPkg::busAddrT  regAddr,
    input  wire legacyPkg::busWordT  writeData,
    input  wire                      writeStrobe,
    input  wire                      chanSel,
    input  wire legacyPkg::demodModeT demodMode,
    input  wire legacyPkg::sampleT   demodSample,
    input  wire legacyPkg::sampleT   trellisSample,
    input  wire legacyPkg::sampleT   multihSample,
    input  wire                      demodSync,
    input  wire                      trellisSync,
    input  wire                      multihSync,
    input  wire                      multihEn,
    output legacyPkg::dacWordT       dacData,
    output legacyPkg::regWordT       readData
);

    legacyPkg::dacSelectT dacSelect;
    legacyPkg::sampleT    chosenSample;
    logic                 chosenSync;
    logic                 trellisPick;
    logic                 multihPick;

    always_comb begin
        case (dacSelect)
            legacyPkg::dacTrellisI,
            legacyPkg::dacTrellisQ,
            legacyPkg::dacTrellisPhErr,
            legacyPkg::dacTrellisIndex: trellisPick = 1'b1;
            default:                    trellisPick = 1'b0;
        endcase
    end

    assign multihPick = multihEn & (demodMode == legacyPkg::modeMultiH);

    //****************************************
    // Select register, choice and hold stages
    //****************************************
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            dacSelect  <= '0;
            chosenSync <= 1'b0;
            dacData    <= '0;
        end else if (softReset) begin
            dacSelect  <= '0;
            chosenSync <= 1'b0;
            dacData    <= '0;
        end else begin
            if (writeStrobe && chanSel && !regAddr[1]) begin
                dacSelect <= writeData[3:0];
            end
            chosenSync <= trellisPick ? trellisSync : (multihPick ? multihSync : demodSync);
            // Upper bits of the sample go to the DAC
            if (chosenSync) begin
                dacData <= chosenSample[$bits(legacyPkg::sampleT)-1 -: $bits(legacyPkg::dacWordT)];
            end
        end
    end

    always_ff @(posedge ck933) begin
        chosenSample <= trellisPick ? trellisSample : (multihPick ? multihSample : demodSample);
    end

    assign readData = {2'b00, dacData, 12'h000, dacSelect};

endmodule

`default_nettype wire

// File: legacyPassThru.sv
//****************************************
// Top of the register and DAC routing core. The data pad
// tristate is built at board level from dataOut and dataOutEn
//****************************************
`timescale 1ns/1ps
`default_nettype none

module legacyPassThru (
    input  wire                       ck933,
    input  wire                       clockCounterEn,
    input  wire                       nCs,
    input  wire                       nWe,
    input  wire                       nRd,
    input  wire legacyPkg::busAddrT   addr,
    input  wire legacyPkg::busWordT   dataIn,
    input  wire legacyPkg::sampleT    demodSample,
    input  wire                       demodSync,
    input  wire legacyPkg::sampleT    trellisSample,
    input  wire                       trellisSync,
    input  wire legacyPkg::sampleT    multihSample,
    input  wire                       multihSync,
    input  wire                       multihEn,
    output legacyPkg::busWordT        dataOut,
    output logic                      dataOutEn,
    output legacyPkg::demodModeT      demodMode,
    output legacyPkg::dacWordT        dac0Data,
    output legacyPkg::dacWordT        dac1Data,
    output legacyPkg::dacWordT        dac2Data
);

    legacyPkg::busAddrT                   regAddr;
    legacyPkg::busWordT                   writeData;
    logic                                 writeStrobe;
    logic                                 readActive;
    logic                                 miscSel;
    logic [legacyPkg::numDacChannels-1:0] chanSel;
    logic                                 softReset;
    legacyPkg::regWordT                   miscData;
    legacyPkg::regWordT                   chanData [legacyPkg::numDacChannels];
    legacyPkg::dacWordT                   dacWord [legacyPkg::numDacChannels];

    //****************************************
    // Bus side
    //****************************************
    busDecoder i_busDecoder (
        .ck933          (ck933),
        .clockCounterEn (clockCounterEn),
        .nCs            (nCs),
        .nWe            (nWe),
        .nRd            (nRd),
        .addr           (addr),
        .dataIn         (dataIn),
        .regAddr        (regAddr),
        .writeData      (writeData),
        .writeStrobe    (writeStrobe),
        .readActive     (readActive),
        .miscSel        (miscSel),
        .chanSel        (chanSel)
    );

    miscRegs i_miscRegs (
        .ck933          (ck933),
        .clockCounterEn (clockCounterEn),
        .regAddr        (regAddr),
        .writeData      (writeData),
        .writeStrobe    (writeStrobe),
        .readActive     (readActive),
        .miscSel        (miscSel),
        .demodMode      (demodMode),
        .softReset      (softReset),
        .readData       (miscData)
    );

    //****************************************
    // DAC channels
    //****************************************
    for (genvar ch = 0; ch < legacyPkg::numDacChannels; ch++) begin : g_dac
        dacChannel i_dacChannel (
            .ck933          (ck933),
            .clockCounterEn (clockCounterEn),
            .softReset      (softReset),
            .regAddr        (regAddr),
            .writeData      (writeData),
            .writeStrobe    (writeStrobe),
            .chanSel        (chanSel[ch]),
            .demodMode      (demodMode),
            .demodSample    (demodSample),
            .trellisSample  (trellisSample),
            .multihSample   (multihSample),
            .demodSync      (demodSync),
            .trellisSync    (trellisSync),
            .multihSync     (multihSync),
            .multihEn       (multihEn),
            .dacData        (dacWord[ch]),
            .readData       (chanData[ch])
        );
    end

    assign dac0Data = dacWord[0];
    assign dac1Data = dacWord[1];
    assign dac2Data = dacWord[2];

    readMux i_readMux (
        .regAddr    (regAddr),
        .readActive (readActive),
        .miscSel    (miscSel),
        .chanSel    (chanSel),
        .miscData   (miscData),
        .chanData   (chanData),
        .dataOut    (dataOut),
        .dataOutEn  (dataOutEn)
    );

endmodule

`default_nettype wire

// File: legacyPassThruTb.sv
//****************************************
// Testbench for the register and DAC routing core. Drives the
// processor bus and sample streams, checks by immediate assertions
//****************************************
`timescale 1ns/1ps
`default_nettype none

module legacyPassThruTb;

    localparam int numTests      = 5;
    localparam int cyclesPerTest = 200;

    logic                 ck933;
    logic                 clockCounterEn;
    logic                 nCs;
    logic                 nWe;
    logic                 nRd;
    legacyPkg::busAddrT   addr;
    legacyPkg::busWordT   dataIn;
    legacyPkg::sampleT    demodSample;
    logic                 demodSync;
    legacyPkg::sampleT    trellisSample;
    logic                 trellisSync;
    legacyPkg::sampleT    multihSample;
    logic                 multihSync;
    logic                 multihEn;
    legacyPkg::busWordT   dataOut;
    logic                 dataOutEn;
    legacyPkg::demodModeT demodMode;
    legacyPkg::dacWordT   dac0Data;
    legacyPkg::dacWordT   dac1Data;
    legacyPkg::dacWordT   dac2Data;

    // Expected state
    legacyPkg::dacSelectT selModel [legacyPkg::numDacChannels];
    legacyPkg::dacWordT   dacModel [legacyPkg::numDacChannels];
    legacyPkg::demodModeT modeModel;
    legacyPkg::busWordT   readWord;
    legacyPkg::busWordT   firstCount;
    int                   gap;

    legacyPassThru i_legacyPassThru (
        .ck933          (ck933),
        .clockCounterEn (clockCounterEn),
        .nCs            (nCs),
        .nWe            (nWe),
        .nRd            (nRd),
        .addr           (addr),
        .dataIn         (dataIn),
        .demodSample    (demodSample),
        .demodSync      (demodSync),
        .trellisSample  (trellisSample),
        .trellisSync    (trellisSync),
        .multihSample   (multihSample),
        .multihSync     (multihSync),
        .multihEn       (multihEn),
        .dataOut        (dataOut),
        .dataOutEn      (dataOutEn),
        .demodMode      (demodMode),
        .dac0Data       (dac0Data),
        .dac1Data       (dac1Data),
        .dac2Data       (dac2Data)
    );

    initial begin
        ck933 = 1'b0;
        forever #10 ck933 = ~ck933;
    end

    initial begin
        repeat (numTests * cyclesPerTest + 100) @(posedge ck933);
        $display("Watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $fatal(1, "Watchdog timeout");
    end

    //****************************************
    // Helpers
    //****************************************
    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", testName, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    function automatic legacyPkg::busAddrT chanAddr(input int ch, input bit upper);
        legacyPkg::busAddrT region;
        case (ch)
            0:       region = legacyPkg::regionInterp0;
            1:       region = legacyPkg::regionInterp1;
            default: region = legacyPkg::regionInterp2;
        endcase
        return region + (upper ? legacyPkg::upperHalf : 12'h000);
    endfunction

    function automatic legacyPkg::busAddrT miscAddr(input legacyPkg::busAddrT offset,
                                                    input bit upper);
        return legacyPkg::regionMisc + offset + (upper ? legacyPkg::upperHalf : 12'h000);
    endfunction

    function automatic legacyPkg::dacWordT dacValue(input int ch);
        case (ch)
            0:       return dac0Data;
            1:       return dac1Data;
            default: return dac2Data;
        endcase
    endfunction

    // Stream code of a channel is 0 demod, 1 trellis or 2 multi-h
    function automatic int streamOf(input int ch);
        if (selModel[ch] inside {legacyPkg::dacTrellisI, legacyPkg::dacTrellisQ,
                                 legacyPkg::dacTrellisPhErr, legacyPkg::dacTrellisIndex}) begin
            return 1;
        end
        if (multihEn && modeModel == legacyPkg::modeMultiH) begin
            return 2;
        end
        return 0;
    endfunction

    // Write completes on the rising nWe and four cycles are allowed after it
    task automatic busWrite(input legacyPkg::busAddrT a, input legacyPkg::busWordT d);
        @(posedge ck933);
        #2;
        addr   = a;
        dataIn = d;
        nCs    = 1'b0;
        nWe    = 1'b0;
        repeat (2) @(posedge ck933);
        #2;
        nWe = 1'b1;
        repeat (4) @(posedge ck933);
        #2;
        nCs = 1'b1;
    endtask

    task automatic busRead(input legacyPkg::busAddrT a, output legacyPkg::busWordT d);
        @(posedge ck933);
        #2;
        addr = a;
        nCs  = 1'b0;
        nRd  = 1'b0;
        repeat (2) @(posedge ck933);
        @(negedge ck933);
        d = dataOut;
        checkValue("read enable", 1, dataOutEn);
        @(posedge ck933);
        #2;
        nCs = 1'b1;
        nRd = 1'b1;
    endtask

    // One sync pulse with a random sample and a check of all DAC ports
    task automatic sendSample(input int stream, input string testName);
        legacyPkg::sampleT value;
        value = legacyPkg::sampleT'($urandom);
        @(posedge ck933);
        #2;
        case (stream)
            0: begin
                demodSample = value;
                demodSync   = 1'b1;
            end
            1: begin
                trellisSample = value;
                trellisSync   = 1'b1;
            end
            default: begin
                multihSample = value;
                multihSync   = 1'b1;
            end
        endcase
        for (int ch = 0; ch < legacyPkg::numDacChannels; ch++) begin
            if (streamOf(ch) == stream) begin
                dacModel[ch] = value[17:4];
            end
        end
        @(posedge ck933);
        #2;
        demodSync   = 1'b0;
        trellisSync = 1'b0;
        multihSync  = 1'b0;
        repeat (2) @(posedge ck933);
        @(negedge ck933);
        for (int ch = 0; ch < legacyPkg::numDacChannels; ch++) begin
            checkValue(testName, dacModel[ch], dacValue(ch));
        end
    endtask

    //****************************************
    // Stimulus
    //****************************************
    initial begin
        void'($urandom(32'ha74f));
        clockCounterEn = 1'b1;
        nCs            = 1'b1;
        nWe            = 1'b1;
        nRd            = 1'b1;
        addr           = '0;
        dataIn         = '0;
        demodSample    = '0;
        demodSync      = 1'b0;
        trellisSample  = '0;
        trellisSync    = 1'b0;
        multihSample   = '0;
        multihSync     = 1'b0;
        multihEn       = 1'b0;
        modeModel      = '0;
        for (int ch = 0; ch < legacyPkg::numDacChannels; ch++) begin
            selModel[ch] = '0;
            dacModel[ch] = '0;
        end
        repeat (3) @(posedge ck933);
        #2;
        clockCounterEn = 1'b0;

        // Test 1 looks at the state after reset
        checkValue("reset dataOutEn", 0, dataOutEn);
        checkValue("reset demodMode", 0, demodMode);
        busRead(miscAddr(legacyPkg::miscVersionOffset, 1'b1), readWord);
        checkValue("version upper", legacyPkg::versionNumber, readWord);
        busRead(miscAddr(legacyPkg::miscVersionOffset, 1'b0), readWord);
        checkValue("version lower", 0, readWord);
        for (int ch = 0; ch < legacyPkg::numDacChannels; ch++) begin
            checkValue("reset dac port", 0, dacValue(ch));
            busRead(chanAddr(ch, 1'b0), readWord);
            checkValue("reset channel lower", 0, readWord);
            busRead(chanAddr(ch, 1'b1), readWord);
            checkValue("reset channel upper", 0, readWord);
        end

        // Test 2 covers select codes and the mode register
        selModel[0] = legacyPkg::dacTrellisI;
        selModel[1] = 4'h5;
        selModel[2] = legacyPkg::dacTrellisIndex;
        for (int ch = 0; ch < legacyPkg::numDacChannels; ch++) begin
            busWrite(chanAddr(ch, 1'b0), {12'h000, selModel[ch]});
        end
        for (int ch = 0; ch < legacyPkg::numDacChannels; ch++) begin
            busRead(chanAddr(ch, 1'b0), readWord);
            checkValue("select readback", {12'h000, selModel[ch]}, readWord);
        end
        modeModel = 4'h6;
        busWrite(miscAddr(legacyPkg::miscModeOffset, 1'b0), {12'h000, modeModel});
        checkValue("mode port", modeModel, demodMode);
        busRead(miscAddr(legacyPkg::miscModeOffset, 1'b0), readWord);
        checkValue("mode readback", modeModel, readWord);

        // Test 3 covers routing and hold
        sendSample(1, "trellis route");
        sendSample(0, "demod route");
        @(posedge ck933);
        #2;
        multihEn  = 1'b1;
        modeModel = legacyPkg::modeMultiH;
        busWrite(miscAddr(legacyPkg::miscModeOffset, 1'b0), {12'h000, modeModel});
        sendSample(2, "multi-h route");
        sendSample(0, "hold without sync");
        busRead(chanAddr(0, 1'b1), readWord);
        checkValue("dac readback", {2'b00, dacModel[0]}, readWord);

        // Test 4 measures the clock counter gap between two captures
        gap = 4 + int'($urandom % 29);
        busWrite(miscAddr(legacyPkg::miscClockOffset, 1'b0), 16'h0000);
        busRead(miscAddr(legacyPkg::miscClockOffset, 1'b0), firstCount);
        repeat (gap - 4) @(posedge ck933);
        busRead(miscAddr(legacyPkg::miscClockOffset, 1'b0), readWord);
        checkValue("clock count gap", gap, readWord - firstCount);

        // Test 5 covers the soft reset
        busRead(miscAddr(legacyPkg::miscResetOffset, 1'b0), readWord);
        repeat (12) @(negedge ck933);
        checkValue("soft reset mode port", 0, demodMode);
        for (int ch = 0; ch < legacyPkg::numDacChannels; ch++) begin
            checkValue("soft reset dac port", 0, dacValue(ch));
            busRead(chanAddr(ch, 1'b0), readWord);
            checkValue("soft reset select", 0, readWord);
        end
        busRead(miscAddr(legacyPkg::miscModeOffset, 1'b0), readWord);
        checkValue("soft reset mode readback", 0, readWord);
        busRead(miscAddr(legacyPkg::miscVersionOffset, 1'b1), readWord);
        checkValue("version after soft reset", legacyPkg::versionNumber, readWord);

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: legacyPassThru_sva.sv
//****************************************
// Concurrent checks on the core's control signals and DAC
// ports. Bound into the top level
//****************************************
`timescale 1ns/1ps
`default_nettype none

module legacyPassThruSva (
    input wire                     ck933,
    input wire                     clockCounterEn,
    input wire                     nCs,
    input wire                     nWe,
    input wire                     nRd,
    input wire                     writeStrobe,
    input wire                     softReset,
    input wire                     dataOutEn,
    input wire                     demodSync,
    input wire                     trellisSync,
    input wire                     multihSync,
    input wire legacyPkg::dacWordT dac0Data,
    input wire legacyPkg::dacWordT dac1Data,
    input wire legacyPkg::dacWordT dac2Data
);

    logic anySync;

    assign anySync = demodSync | trellisSync | multihSync;

    // Strobe two cycles after the rising nWe and for one cycle only
    strobeOneCycle: assert property (@(posedge ck933) disable iff (clockCounterEn)
        $rose(nWe) && !nCs |-> ##2 writeStrobe ##1 !writeStrobe)
        else $error("writeStrobe missing or held for two cycles");

    // Pulse must span exactly the fixed count of clocks
    softResetLength: assert property (@(posedge ck933) disable iff (clockCounterEn)
        $fell(softReset) |-> $past(softReset, legacyPkg::softResetCycles)
                             && !$past(softReset, legacyPkg::softResetCycles + 1))
        else $error("softReset pulse length wrong");

    // Enable is the bus read level one register stage later
    enableFollowsRead: assert property (@(posedge ck933) disable iff (clockCounterEn)
        dataOutEn == $past(!nCs && !nRd))
        else $error("dataOutEn does not follow the registered read");

    //****************************************
    // DAC ports move only after a sync or a soft reset
    //****************************************
    dac0Steady: assert property (@(posedge ck933) disable iff (clockCounterEn)
        $changed(dac0Data) |-> $past(anySync, 2) || $past(softReset))
        else $error("dac0Data changed without a sync");

    dac1Steady: assert property (@(posedge ck933) disable iff (clockCounterEn)
        $changed(dac1Data) |-> $past(anySync, 2) || $past(softReset))
        else $error("dac1Data changed without a sync");

    dac2Steady: assert property (@(posedge ck933) disable iff (clockCounterEn)
        $changed(dac2Data) |-> $past(anySync, 2) || $past(softReset))
        else $error("dac2Data changed without a sync");

endmodule

bind legacyPassThru legacyPassThruSva i_legacyPassThruSva (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .nCs            (nCs),
    .nWe            (nWe),
    .nRd            (nRd),
    .writeStrobe    (writeStrobe),
    .softReset      (softReset),
    .dataOutEn      (dataOutEn),
    .demodSync      (demodSync),
    .trellisSync    (trellisSync),
    .multihSync     (multihSync),
    .dac0Data       (dac0Data),
    .dac1Data       (dac1Data),
    .dac2Data       (dac2Data)
);

`default_nettype wire

// File: legacyPkg.sv
//****************************************
// Widths, address map and codes shared by the register and
// DAC routing core. Files use these by scoped names
//****************************************
`default_nettype none

package legacyPkg;

    // Bus and data widths
    typedef logic [11:0] busAddrT;
    typedef logic [15:0] busWordT;
    typedef logic [31:0] regWordT;
    typedef logic [17:0] sampleT;
    typedef logic [13:0] dacWordT;
    typedef logic [3:0]  dacSelectT;
    typedef logic [3:0]  demodModeT;

    localparam int numDacChannels = 3;

    //****************************************
    // Address map
    //****************************************
    // Region lives in bits 11 to 5, word offset in bits 4 to 2
    localparam busAddrT regionMask = 12'hfe0;
    localparam busAddrT offsetMask = 12'h01c;
    localparam busAddrT upperHalf  = 12'h002;

    localparam busAddrT regionMisc    = 12'h800;
    localparam busAddrT regionInterp0 = 12'h900;
    localparam busAddrT regionInterp1 = 12'h920;
    localparam busAddrT regionInterp2 = 12'h940;

    // Misc region word offsets
    localparam busAddrT miscResetOffset   = 12'h000;
    localparam busAddrT miscVersionOffset = 12'h004;
    localparam busAddrT miscClockOffset   = 12'h008;
    localparam busAddrT miscModeOffset    = 12'h00c;

    //****************************************
    // Select and mode codes
    //****************************************
    localparam dacSelectT dacTrellisI     = 4'h8;
    localparam dacSelectT dacTrellisQ     = 4'h9;
    localparam dacSelectT dacTrellisPhErr = 4'ha;
    localparam dacSelectT dacTrellisIndex = 4'hb;

    localparam demodModeT modeMultiH = 4'hb;

    localparam busWordT versionNumber = 16'h0159;

    // Soft reset pulse length in clocks
    localparam int softResetCycles = 6;
    typedef logic [$clog2(softResetCycles)-1:0] resetCountT;

endpackage

`default_nettype wire

// File: miscRegs.sv
//****************************************
// Misc register space with version word, cycle counter,
// soft reset generator and the demod mode register
//****************************************
`timescale 1ns/1ps
`default_nettype none

module miscRegs (
    input  wire                     ck933,
    input  wire                     clockCounterEn,
    input  wire legacyPkg::busAddrT regAddr,
    input  wire legacyPkg::busWordT writeData,
    input  wire                     writeStrobe,
    input  wire                     readActive,
    input  wire                     miscSel,
    output legacyPkg::demodModeT    demodMode,
    output logic                    softReset,
    output legacyPkg::regWordT      readData
);

    legacyPkg::busAddrT    offset;
    legacyPkg::regWordT    clockCounter;
    legacyPkg::regWordT    clockHold;
    legacyPkg::resetCountT resetCount;
    logic                  modeWrite;
    logic                  clockRestart;
    logic                  resetRead;
    logic                  resetReadDly;
    logic                  miscSelDly;

    assign offset = regAddr & legacyPkg::offsetMask;

    // Mode takes the low half only
    assign modeWrite    = writeStrobe & miscSel & ~regAddr[1]
                        & (offset == legacyPkg::miscModeOffset);
    assign clockRestart = writeStrobe & miscSel & (offset == legacyPkg::miscClockOffset);
    assign resetRead    = readActive & miscSel & (offset == legacyPkg::miscResetOffset);

    //****************************************
    // Mode register and cycle counter
    //****************************************
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            demodMode    <= '0;
            clockCounter <= '0;
            miscSelDly   <= 1'b0;
        end else begin
            miscSelDly <= miscSel;
            if (softReset) begin
                demodMode <= '0;
            end else if (modeWrite) begin
                demodMode <= writeData[3:0];
            end
            if (clockRestart) begin
                clockCounter <= '0;
            end else begin
                clockCounter <= clockCounter + 1'b1;
            end
        end
    end

    // Snapshot on the first cycle of each misc access
    always_ff @(posedge ck933) begin
        if (miscSel && !miscSelDly) begin
            clockHold <= clockCounter;
        end
    end

    //****************************************
    // Soft reset pulse
    //****************************************
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            resetReadDly <= 1'b0;
            resetCount   <= '0;
            softReset    <= 1'b0;
        end else begin
            resetReadDly <= resetRead;
            // One pulse per read however long the read is held
            if (resetRead && !resetReadDly) begin
                softReset  <= 1'b1;
                resetCount <= legacyPkg::resetCountT'(legacyPkg::softResetCycles - 1);
            end else if (resetCount != '0) begin
                resetCount <= resetCount - 1'b1;
            end else begin
                softReset <= 1'b0;
            end
        end
    end

    // Read word by offset
    always_comb begin
        case (offset)
            legacyPkg::miscVersionOffset: readData = {legacyPkg::versionNumber, 16'h0000};
            legacyPkg::miscClockOffset:   readData = clockHold;
            legacyPkg::miscModeOffset:    readData = {28'h0000000, demodMode};
            default:                      readData = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: readMux.sv
//****************************************
// Processor read data. Region word, then half word by bit 1
//****************************************
`timescale 1ns/1ps
`default_nettype none

module readMux (
    input  wire legacyPkg::busAddrT              regAddr,
    input  wire                                  readActive,
    input  wire                                  miscSel,
    input  wire [legacyPkg::numDacChannels-1:0]  chanSel,
    input  wire legacyPkg::regWordT              miscData,
    input  wire legacyPkg::regWordT              chanData [legacyPkg::numDacChannels],
    output legacyPkg::busWordT                   dataOut,
    output logic                                 dataOutEn
);

    legacyPkg::regWordT regionWord;

    // Unmapped regions read as zero
    always_comb begin
        regionWord = '0;
        if (miscSel) begin
            regionWord = miscData;
        end
        for (int i = 0; i < legacyPkg::numDacChannels; i++) begin
            if (chanSel[i]) begin
                regionWord = chanData[i];
            end
        end
    end

    assign dataOut   = regAddr[1] ? regionWord[31:16] : regionWord[15:0];
    assign dataOutEn = readActive;

endmodule

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches the log for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module legacyPassThruTb -o simTb

./obj_dir/simTb | tee sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: sources.f
legacyPkg.sv
busDecoder.sv
miscRegs.sv
dacChannel.sv
readMux.sv
legacyPassThru.sv
legacyPassThru_sva.sv
legacyPassThruTb.sv
